//--- hw/lsu_pkg.sv
// ------------------------------------------------
// load/store unit shared definitions
// widths, cause codes, pipe depths and record types
// ------------------------------------------------
`default_nettype none

package lsu_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned BE_W       = XLEN / 8;
  localparam int unsigned TRANS_ID_W = 3;
  localparam int unsigned CAUSE_W    = 5;

  // mcause values for misaligned data access
  localparam logic [CAUSE_W-1:0] LD_ADDR_MISALIGNED = 5'd4;
  localparam logic [CAUSE_W-1:0] ST_ADDR_MISALIGNED = 5'd6;

  // output register stages per path
  localparam int unsigned LOAD_PIPE_DEPTH  = 1;
  localparam int unsigned STORE_PIPE_DEPTH = 2;

  // ------------------------------------------------
  // types
  // ------------------------------------------------
  // loads first, stores in the upper codes
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LBU = 3'd1,
    LH  = 3'd2,
    LHU = 3'd3,
    LW  = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  typedef struct packed {
    logic                 valid;
    logic [CAUSE_W-1:0]   cause;
    // faulting address
    logic [XLEN-1:0]      tval;
  } exception_t;

  // from issue stage, imm already sign-extended
  typedef struct packed {
    lsu_op_e              op;
    logic [XLEN-1:0]      operand_a;
    logic [XLEN-1:0]      operand_b;
    logic [XLEN-1:0]      imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  // agu output, held in the issue register
  typedef struct packed {
    lsu_op_e              op;
    logic [XLEN-1:0]      vaddr;
    // already placed in its byte lane
    logic [XLEN-1:0]      wdata;
    logic [BE_W-1:0]      be;
    logic [TRANS_ID_W-1:0] trans_id;
    exception_t           ex;
  } lsu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]      data;
    exception_t           ex;
  } lsu_result_t;

  // data memory port, addr word aligned
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [XLEN-1:0]      addr;
    logic [BE_W-1:0]      be;
    logic [XLEN-1:0]      wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic [XLEN-1:0]      rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/lsu_agu.sv
// ------------------------------------------------
// address generation unit
// effective address, byte enables, store lane and
// misaligned access detection
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lsu_agu (
  input  lsu_pkg::fu_data_t fu_data_i,
  output lsu_pkg::lsu_req_t req_o
);

  logic [lsu_pkg::XLEN-1:0] vaddr;
  // 0 byte, 1 half, 2 word
  logic [1:0]               size;
  logic                     is_store;
  logic                     misaligned;
  logic [lsu_pkg::BE_W-1:0] be;

  // base plus sign-extended offset
  assign vaddr = fu_data_i.operand_a + fu_data_i.imm;

  // ------------------------------------------------
  // op decode
  // ------------------------------------------------
  always_comb begin
    size     = 2'd0;
    is_store = 1'b0;
    case (fu_data_i.op)
      lsu_pkg::LH, lsu_pkg::LHU: size = 2'd1;
      lsu_pkg::LW: size = 2'd2;
      lsu_pkg::SB: is_store = 1'b1;
      lsu_pkg::SH: begin
        size     = 2'd1;
        is_store = 1'b1;
      end
      lsu_pkg::SW: begin
        size     = 2'd2;
        is_store = 1'b1;
      end
      // byte loads keep the defaults
      default: ;
    endcase
  end

  // byte enables from low address bits
  always_comb begin
    case (size)
      2'd0:    be = 4'b0001 << vaddr[1:0];
      2'd1:    be = 4'b0011 << vaddr[1:0];
      default: be = 4'b1111;
    endcase
  end

  // byte never misaligned
  always_comb begin
    case (size)
      2'd1:    misaligned = vaddr[0];
      2'd2:    misaligned = |vaddr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  // ------------------------------------------------
  // request record
  // ------------------------------------------------
  always_comb begin
    req_o          = '0;
    req_o.op       = fu_data_i.op;
    req_o.vaddr    = vaddr;
    // move store data into the addressed lane
    req_o.wdata    = fu_data_i.operand_b << {vaddr[1:0], 3'b000};
    req_o.be       = be;
    req_o.trans_id = fu_data_i.trans_id;
    if (misaligned) begin
      req_o.ex.valid = 1'b1;
      req_o.ex.cause = is_store ? lsu_pkg::ST_ADDR_MISALIGNED : lsu_pkg::LD_ADDR_MISALIGNED;
      req_o.ex.tval  = vaddr;
    end
  end

  // aligned access enables exactly its size in bytes, none lost to the shift
  always_comb begin
    if (!misaligned) begin
      be_width_a: assert final ($countones(be) == (1 << size))
        else $error("lsu_agu: byte enables %b do not cover size %0d", be, size);
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_issue.sv
// ------------------------------------------------
// single-entry request register
// holds one operation and routes it to load or store
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lsu_issue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output lsu_pkg::lsu_req_t ctrl_o,
  output logic              ld_valid_o,
  output logic              st_valid_o,
  input  logic              pop_ld_i,
  input  logic              pop_st_i
);

  logic              valid_q;
  lsu_pkg::lsu_req_t req_q;
  logic              accept;
  logic              is_load;

  // ready only while empty
  assign ready_o = ~valid_q;
  assign accept  = valid_i & ready_o;

  // fill on accept, clear on either pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (pop_ld_i || pop_st_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // op class
  always_comb begin
    case (req_q.op)
      lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW: is_load = 1'b0;
      default: is_load = 1'b1;
    endcase
  end

  assign ctrl_o     = req_q;
  assign ld_valid_o = valid_q & is_load;
  assign st_valid_o = valid_q & ~is_load;

  // only the owning path may retire the operation
  pop_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_ld_i && pop_st_i))
    else $error("lsu_issue: load and store pop together");

  // a pop always retires a held request
  pop_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_ld_i || pop_st_i) |-> valid_q)
    else $error("lsu_issue: pop with empty register");

endmodule

`default_nettype wire

//--- hw/load_unit.sv
// ------------------------------------------------
// load path
// read request, response wait, lane extract and
// sign or zero extension
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module load_unit (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              valid_i,
  input  lsu_pkg::lsu_req_t ctrl_i,
  output lsu_pkg::mem_req_t mem_req_o,
  input  lsu_pkg::mem_rsp_t mem_rsp_i,
  output logic              pop_o,
  output lsu_pkg::lsu_result_t result_o
);

  typedef enum logic {
    IDLE,
    WAIT
  } load_state_e;

  load_state_e                    state_q;
  load_state_e                    state_d;
  logic                           issue;
  logic                           ex_done;
  logic                           rsp_done;
  logic                           done;
  logic [lsu_pkg::XLEN-1:0]       shifted;
  logic [lsu_pkg::XLEN-1:0]       ld_data;
  logic                           res_valid_q;
  logic [lsu_pkg::TRANS_ID_W-1:0] res_id_q;
  logic [lsu_pkg::XLEN-1:0]       res_data_q;
  lsu_pkg::exception_t            res_ex_q;

  // ------------------------------------------------
  // control
  // ------------------------------------------------
  // misaligned load skips memory entirely
  assign issue    = (state_q == IDLE) & valid_i & ~ctrl_i.ex.valid;
  assign ex_done  = (state_q == IDLE) & valid_i & ctrl_i.ex.valid;
  assign rsp_done = (state_q == WAIT) & mem_rsp_i.rvalid;
  assign done     = ex_done | rsp_done;
  assign pop_o    = done;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (issue) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (mem_rsp_i.rvalid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // read strobe for one cycle
  always_comb begin
    mem_req_o       = '0;
    mem_req_o.req   = issue;
    mem_req_o.we    = 1'b0;
    mem_req_o.addr  = {ctrl_i.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
    mem_req_o.be    = ctrl_i.be;
  end

  // ------------------------------------------------
  // data extraction
  // ------------------------------------------------
  // addressed byte or half down to bit 0
  assign shifted = mem_rsp_i.rdata >> {ctrl_i.vaddr[1:0], 3'b000};

  always_comb begin
    case (ctrl_i.op)
      lsu_pkg::LB:  ld_data = {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
      lsu_pkg::LBU: ld_data = {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
      lsu_pkg::LH:  ld_data = {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
      lsu_pkg::LHU: ld_data = {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
      // word
      default:      ld_data = shifted;
    endcase
  end

  // result register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done) begin
      res_id_q   <= ctrl_i.trans_id;
      res_data_q <= ctrl_i.ex.valid ? '0 : ld_data;
      res_ex_q   <= ctrl_i.ex;
    end
  end

  assign result_o.valid    = res_valid_q;
  assign result_o.trans_id = res_id_q;
  assign result_o.data     = res_data_q;
  assign result_o.ex       = res_ex_q;

  // memory answers only an outstanding read
  rvalid_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.rvalid |-> (state_q == WAIT))
    else $error("load_unit: rvalid without outstanding read");

endmodule

`default_nettype wire

//--- hw/store_unit.sv
// ------------------------------------------------
// store path
// single-cycle write request and store result
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module store_unit (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              valid_i,
  input  lsu_pkg::lsu_req_t ctrl_i,
  output lsu_pkg::mem_req_t mem_req_o,
  output logic              pop_o,
  output lsu_pkg::lsu_result_t result_o
);

  logic                           res_valid_q;
  logic [lsu_pkg::TRANS_ID_W-1:0] res_id_q;
  lsu_pkg::exception_t            res_ex_q;

  // ------------------------------------------------
  // write request
  // ------------------------------------------------
  // no response expected, retire in the request cycle
  always_comb begin
    mem_req_o       = '0;
    mem_req_o.req   = valid_i & ~ctrl_i.ex.valid;
    mem_req_o.we    = 1'b1;
    mem_req_o.addr  = {ctrl_i.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
    mem_req_o.be    = ctrl_i.be;
    mem_req_o.wdata = ctrl_i.wdata;
  end

  assign pop_o = valid_i;

  // ------------------------------------------------
  // result
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_id_q <= ctrl_i.trans_id;
      res_ex_q <= ctrl_i.ex;
    end
  end

  // stores carry no data back
  assign result_o.valid    = res_valid_q;
  assign result_o.trans_id = res_id_q;
  assign result_o.data     = '0;
  assign result_o.ex       = res_ex_q;

endmodule

`default_nettype wire

//--- hw/result_pipe.sv
// ------------------------------------------------
// result shift register
// fixed-depth delay line for result records
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module result_pipe #(
  parameter int unsigned Depth = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_result_t d_i,
  output lsu_pkg::lsu_result_t d_o
);

  lsu_pkg::lsu_result_t stage_q [Depth];

  if (Depth < 1) begin : gen_depth_check
    $error("result_pipe: Depth must be at least 1");
  end

  // stage 0 takes the input, the rest shift along
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign d_o = stage_q[Depth-1];

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
// ------------------------------------------------
// load/store unit top
// agu, request register, load and store paths and
// their result pipes on one memory port
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::fu_data_t    fu_data_i,
  input  logic                 lsu_valid_i,
  output logic                 lsu_ready_o,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  lsu_pkg::mem_rsp_t    mem_rsp_i,
  output lsu_pkg::lsu_result_t load_result_o,
  output lsu_pkg::lsu_result_t store_result_o
);

  lsu_pkg::lsu_req_t    agu_req;
  lsu_pkg::lsu_req_t    ctrl;
  logic                 ld_valid;
  logic                 st_valid;
  logic                 pop_ld;
  logic                 pop_st;
  lsu_pkg::mem_req_t    ld_mem_req;
  lsu_pkg::mem_req_t    st_mem_req;
  lsu_pkg::lsu_result_t ld_result;
  lsu_pkg::lsu_result_t st_result;

  lsu_agu lsu_agu_inst (
    .fu_data_i (fu_data_i),
    .req_o     (agu_req)
  );

  lsu_issue lsu_issue_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (agu_req),
    .valid_i    (lsu_valid_i),
    .ready_o    (lsu_ready_o),
    .ctrl_o     (ctrl),
    .ld_valid_o (ld_valid),
    .st_valid_o (st_valid),
    .pop_ld_i   (pop_ld),
    .pop_st_i   (pop_st)
  );

  // ------------------------------------------------
  // paths
  // ------------------------------------------------
  load_unit load_unit_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (ld_valid),
    .ctrl_i    (ctrl),
    .mem_req_o (ld_mem_req),
    .mem_rsp_i (mem_rsp_i),
    .pop_o     (pop_ld),
    .result_o  (ld_result)
  );

  store_unit store_unit_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (st_valid),
    .ctrl_i    (ctrl),
    .mem_req_o (st_mem_req),
    .pop_o     (pop_st),
    .result_o  (st_result)
  );

  // load path owns the port while a load is held
  assign mem_req_o = ld_valid ? ld_mem_req : st_mem_req;

  // ------------------------------------------------
  // output pipes
  // ------------------------------------------------
  result_pipe #(
    .Depth (lsu_pkg::LOAD_PIPE_DEPTH)
  ) load_pipe_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_result_o)
  );

  result_pipe #(
    .Depth (lsu_pkg::STORE_PIPE_DEPTH)
  ) store_pipe_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_result_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_load_store_unit.sv
// ------------------------------------------------
// load/store unit testbench
// random loads and stores against a memory model,
// checked by concurrent assertions
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_load_store_unit;

  localparam int NUM_OPS     = 300;
  localparam int WAIT_CYCLES = 40;

  logic                 clk_i;
  logic                 rst_ni;
  lsu_pkg::fu_data_t    fu_data_i;
  logic                 lsu_valid_i;
  logic                 lsu_ready_o;
  lsu_pkg::mem_req_t    mem_req_o;
  lsu_pkg::mem_rsp_t    mem_rsp_i;
  lsu_pkg::lsu_result_t load_result_o;
  lsu_pkg::lsu_result_t store_result_o;

  // memory model and the reference copy kept by the driver
  logic [31:0] mem    [64];
  logic [31:0] shadow [64];
  logic [31:0] mem_rand;
  logic [2:0]  rd_cnt;
  logic [5:0]  rd_idx;

  // expected record of the operation in flight
  logic                          exp_is_store;
  logic                          exp_mis;
  logic [3:0]                    exp_be;
  logic [31:0]                   exp_addr;
  logic [31:0]                   exp_wdata;
  logic [31:0]                   exp_data;
  logic [2:0]                    exp_id;
  lsu_pkg::exception_t           exp_ex;
  logic                          accept;
  int                            req_cnt;
  int                            errors;
  int                            timeouts;

  load_store_unit load_store_unit_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fu_data_i      (fu_data_i),
    .lsu_valid_i    (lsu_valid_i),
    .lsu_ready_o    (lsu_ready_o),
    .mem_req_o      (mem_req_o),
    .mem_rsp_i      (mem_rsp_i),
    .load_result_o  (load_result_o),
    .store_result_o (store_result_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  assign accept = lsu_valid_i && lsu_ready_o;

  // ------------------------------------------------
  // memory model
  // ------------------------------------------------
  // writes by byte enable, reads answered after 1 to 4 cycles
  always @(posedge clk_i) begin
    mem_rsp_i.rvalid <= 1'b0;
    if (rd_cnt == 3'd1) begin
      mem_rsp_i.rvalid <= 1'b1;
      mem_rsp_i.rdata  <= mem[rd_idx];
      rd_cnt           <= 3'd0;
    end else if (rd_cnt > 3'd1) begin
      rd_cnt <= rd_cnt - 3'd1;
    end
    if (rst_ni && mem_req_o.req) begin
      if (mem_req_o.we) begin
        for (int j = 0; j < 4; j++) begin
          if (mem_req_o.be[j]) begin
            mem[mem_req_o.addr[7:2]][8*j +: 8] <= mem_req_o.wdata[8*j +: 8];
          end
        end
      end else begin
        mem_rand <= lcg_next(mem_rand);
        rd_cnt   <= 3'd1 + 3'(mem_rand[17:16]);
        rd_idx   <= mem_req_o.addr[7:2];
      end
    end
  end

  // memory requests since the last acceptance
  always @(posedge clk_i) begin
    if (accept) begin
      req_cnt <= 0;
    end else if (mem_req_o.req) begin
      req_cnt <= req_cnt + 1;
    end
  end

  // ------------------------------------------------
  // checking assertions
  // ------------------------------------------------
  // byte enables on every request, lane data on writes
  be_wdata_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> (mem_req_o.be == exp_be
                       && (!mem_req_o.we || mem_req_o.wdata == exp_wdata)))
    else begin
      errors++;
      $display("mismatch mem_req_o.be/wdata: got %h/%h expected %h/%h",
               mem_req_o.be, mem_req_o.wdata, exp_be, exp_wdata);
    end

  addr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> (mem_req_o.addr == {exp_addr[31:2], 2'b00}
                       && mem_req_o.we == exp_is_store))
    else begin
      errors++;
      $display("mismatch mem_req_o.addr/we: got %h/%h expected %h/%h",
               mem_req_o.addr, mem_req_o.we, {exp_addr[31:2], 2'b00}, exp_is_store);
    end

  mis_noreq_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> !exp_mis)
    else begin
      errors++;
      $display("memory request issued for a misaligned access");
    end

  one_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> req_cnt == 0)
    else begin
      errors++;
      $display("more than one memory request for one operation");
    end

  ld_res_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_result_o.valid |-> (!exp_is_store && load_result_o.data == exp_data
                             && load_result_o.ex == exp_ex && load_result_o.trans_id == exp_id))
    else begin
      errors++;
      $display("mismatch load_result_o: got %h expected data %h ex %h id %h",
               load_result_o, exp_data, exp_ex, exp_id);
    end

  st_res_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_result_o.valid |-> (exp_is_store && store_result_o.data == 32'h0
                              && store_result_o.ex == exp_ex
                              && store_result_o.trans_id == exp_id))
    else begin
      errors++;
      $display("mismatch store_result_o: got %h expected data 0 ex %h id %h",
               store_result_o, exp_ex, exp_id);
    end

  // register valid one cycle after acceptance, then unit and pipe
  st_time_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && exp_is_store) |-> ##(lsu_pkg::STORE_PIPE_DEPTH + 2) store_result_o.valid)
    else begin
      errors++;
      $display("store result not valid at the expected cycle");
    end

  mis_ld_time_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && !exp_is_store && exp_mis) |-> ##(lsu_pkg::LOAD_PIPE_DEPTH + 2) load_result_o.valid)
    else begin
      errors++;
      $display("misaligned load result not valid at the expected cycle");
    end

  busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> !lsu_ready_o)
    else begin
      errors++;
      $display("ready still high after acceptance");
    end

  // stores and misaligned loads pop in the register-valid cycle
  st_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && (exp_is_store || exp_mis)) |-> ##1 !lsu_ready_o ##1 lsu_ready_o)
    else begin
      errors++;
      $display("ready did not return after single-cycle pop");
    end

  // read outstanding up to and including its response
  ld_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_cnt != 3'd0 || mem_rsp_i.rvalid) |-> !lsu_ready_o)
    else begin
      errors++;
      $display("ready high while a load is outstanding");
    end

  ld_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.rvalid |=> lsu_ready_o)
    else begin
      errors++;
      $display("ready did not return after load response");
    end

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------
  task automatic run_op(input logic [2:0] op, input logic [7:0] vaddr,
                        input logic [31:0] imm, input logic [31:0] data,
                        input logic [2:0] id);
    logic [1:0]  size;
    logic        st;
    logic        mis;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] word;
    logic [31:0] ld;
    logic [4:0]  off;
    int          t;
    st    = op >= 3'd5;
    size  = (op == 3'd4 || op == 3'd7) ? 2'd2 :
            (op == 3'd2 || op == 3'd3 || op == 3'd6) ? 2'd1 : 2'd0;
    mis   = (size == 2'd1) ? vaddr[0] : (size == 2'd2) ? |vaddr[1:0] : 1'b0;
    be    = (size == 2'd2) ? 4'hf : (size == 2'd1) ? (4'h3 << vaddr[1:0]) : (4'h1 << vaddr[1:0]);
    off   = {vaddr[1:0], 3'b000};
    wdata = data << off;
    word  = shadow[vaddr[7:2]] >> off;
    case (op)
      3'd0:    ld = {{24{word[7]}}, word[7:0]};
      3'd1:    ld = {24'h0, word[7:0]};
      3'd2:    ld = {{16{word[15]}}, word[15:0]};
      3'd3:    ld = {16'h0, word[15:0]};
      default: ld = word;
    endcase
    @(posedge clk_i);
    fu_data_i.op        <= lsu_pkg::lsu_op_e'(op);
    fu_data_i.operand_a <= {24'h0, vaddr} - imm;
    fu_data_i.operand_b <= data;
    fu_data_i.imm       <= imm;
    fu_data_i.trans_id  <= id;
    lsu_valid_i         <= 1'b1;
    exp_is_store        <= st;
    exp_mis             <= mis;
    exp_be              <= be;
    exp_addr            <= {24'h0, vaddr};
    exp_wdata           <= wdata;
    exp_data            <= (st || mis) ? 32'h0 : ld;
    exp_id              <= id;
    exp_ex.valid        <= mis;
    exp_ex.cause        <= mis ? (st ? 5'd6 : 5'd4) : 5'd0;
    exp_ex.tval         <= mis ? {24'h0, vaddr} : 32'h0;
    // reference memory takes the store bytes
    if (st && !mis) begin
      for (int j = 0; j < 4; j++) begin
        if (be[j]) shadow[vaddr[7:2]][8*j +: 8] = wdata[8*j +: 8];
      end
    end
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!lsu_ready_o && t < WAIT_CYCLES);
    lsu_valid_i <= 1'b0;
    if (t >= WAIT_CYCLES) begin
      timeouts++;
      $display("timeout waiting for lsu_ready_o");
    end
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!(load_result_o.valid || store_result_o.valid) && t < WAIT_CYCLES);
    if (t >= WAIT_CYCLES) begin
      timeouts++;
      $display("timeout waiting for a result");
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  va;
    logic [2:0]  op;
    errors      = 0;
    timeouts    = 0;
    r           = 32'd44846;
    mem_rand    = 32'd44846;
    rd_cnt      = 3'd0;
    rd_idx      = 6'd0;
    req_cnt     = 0;
    rst_ni      = 1'b0;
    lsu_valid_i = 1'b0;
    fu_data_i   = '0;
    mem_rsp_i   = '0;
    // fill depends on every address bit
    for (int i = 0; i < 64; i++) begin
      mem[i]    = (32'(i) * 32'h9e3779b1) ^ {26'(i), 6'(i)};
      shadow[i] = mem[i];
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    reset_a: assert (lsu_ready_o && !mem_req_o.req && !load_result_o.valid
                     && !store_result_o.valid)
      else begin
        errors++;
        $display("outputs not idle after reset");
      end
    for (int n = 0; n < NUM_OPS; n++) begin
      r  = lcg_next(r);
      op = r[30:28];
      va = {2'b00, r[21:16]};
      // three aligned accesses, then a forced misaligned one
      if (n % 4 == 3) begin
        va[0] = 1'b1;
        if (op == 3'd0 || op == 3'd1) op = 3'd2;
        if (op == 3'd5) op = 3'd7;
      end else if (op == 3'd4 || op == 3'd7) begin
        va[1:0] = 2'b00;
      end else if (op == 3'd2 || op == 3'd3 || op == 3'd6) begin
        va[0] = 1'b0;
      end
      run_op(op, va, {{25{r[14]}}, r[14:8]}, lcg_next(r), 3'(n));
    end
    repeat (4) @(posedge clk_i);
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hw/lsu_pkg.sv
hw/lsu_agu.sv
hw/lsu_issue.sv
hw/load_unit.sv
hw/store_unit.sv
hw/result_pipe.sv
hw/load_store_unit.sv
testbench/tb_load_store_unit.sv

//--- Makefile
TOOL      = verilator
TOP       = tb_load_store_unit
FILELIST  = project.f
FLAGS     = --binary --timing --assert -j 0
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
